// File: axis_ram_buffer.f
src/axis_ram_pkg.sv
src/frame_ram.sv
src/frame_writer.sv
src/replay_addr_gen.sv
src/read_fifo.sv
src/axis_out_pipe.sv
src/axis_ram_buffer.sv
verification/tb_axis_ram_buffer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the replay buffer testbench with Verilator and runs it into a log

set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_axis_ram_buffer
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -f axis_ram_buffer.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
  echo "Simulation FAILED, see $LOG"
  exit 1
fi

if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation passed"
exit 0

// File: verification/tb_axis_ram_buffer.sv
// Runs with DEPTH 64, FRAME_LEN 48 and FIFO_DEPTH 4; stops at the first mismatch or timeout
`timescale 1ns/10ps

module tb_axis_ram_buffer;

  import axis_ram_pkg::*;

  localparam int DEPTH      = 64;
  localparam int FRAME_LEN  = 48;
  localparam int FIFO_DEPTH = 4;
  localparam int TIMEOUT    = 2000;  // Cycles per wait loop

  logic        axis_wr_inf;
  logic        rst_n;
  logic        wr_en;
  axis_beat_t  wr_beat;
  logic        wr_ready;
  logic        gen_en;
  logic        gen_ready;
  axis_beat_t  rd_beat;
  logic        rd_ready;

  logic [31:0] lcg_state;       // Random generator state
  logic [7:0]  model [DEPTH];   // Expected RAM contents
  int          wptr;            // Expected write address

  axis_ram_buffer #(
    .DEPTH      (DEPTH),
    .FRAME_LEN  (FRAME_LEN),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) axis_ram_buffer_inst (
    .axis_wr_inf (axis_wr_inf),
    .rst_n       (rst_n),
    .wr_en       (wr_en),
    .wr_beat     (wr_beat),
    .wr_ready    (wr_ready),
    .gen_en      (gen_en),
    .gen_ready   (gen_ready),
    .rd_beat     (rd_beat),
    .rd_ready    (rd_ready)
  );

  always #10 axis_wr_inf = ~axis_wr_inf;  // 20 ns period

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'h0000, lcg_state[31:16]};  // Upper bits are the better ones
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      $display("FAILED %s expected 0x%0h actual 0x%0h", name, exp, act);
      $display("Errors found");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Errors found");
    $fatal(1, "Wait loop timed out");
  endtask

  // Idle outputs: producer free, no beat on the read side
  task automatic check_idle(input int n);
    repeat (n) begin
      @(negedge axis_wr_inf);
      expect_equal("gen_ready", 32'(1'b1), 32'(gen_ready));
      expect_equal("rd_beat.valid", 32'(1'b0), 32'(rd_beat.valid));
    end
  endtask

  // Writes one frame of len beats, last on the final one
  task automatic write_frame(input int len, input bit gaps);
    int          sent;
    int          cycles;
    logic        pending;
    logic [7:0]  byte_q;
    logic [31:0] r;
    sent    = 0;
    cycles  = 0;
    pending = 1'b0;
    byte_q  = 8'h00;
    while (sent < len) begin
      @(negedge axis_wr_inf);
      if (!pending && (!gaps || (next_rand() % 32'd4) != 32'd0)) begin
        r       = next_rand();
        byte_q  = r[7:0];  // New beat, held until taken
        pending = 1'b1;
      end
      wr_en   = gaps ? ((next_rand() % 32'd4) != 32'd0) : 1'b1;
      wr_beat = '{valid: pending, last: pending && (sent == len - 1), data: byte_q};
      #1;
      expect_equal("wr_ready", 32'(wr_en), 32'(wr_ready));
      if (pending && wr_en) begin
        model[wptr] = byte_q;
        wptr        = (sent == len - 1) ? 0 : (wptr + 1) % DEPTH;  // Reset after last
        sent        = sent + 1;
        pending     = 1'b0;
      end
      cycles = cycles + 1;
      if (cycles > TIMEOUT) begin
        report_timeout("write frame to be accepted");
      end
    end
    @(negedge axis_wr_inf);
    wr_beat = '0;
    wr_en   = 1'b1;
  endtask

  // Beats offered with wr_en low must not reach the RAM
  task automatic offer_while_disabled(input int n);
    logic [31:0] r;
    r = next_rand();
    @(negedge axis_wr_inf);
    wr_en   = 1'b0;
    wr_beat = '{valid: 1'b1, last: r[8], data: r[7:0]};
    repeat (n) begin
      #1;
      expect_equal("wr_ready", 32'(1'b0), 32'(wr_ready));
      @(negedge axis_wr_inf);
    end
    wr_beat = '0;
    wr_en   = 1'b1;
  endtask

  // One replay checked against the model, optional back-pressure and ignored start
  task automatic run_replay(input bit backpressure, input bit extra_start);
    logic [7:0] exp_data [FRAME_LEN];
    int         idx;
    int         cycles;
    logic       prev_stall;
    axis_beat_t prev_beat;
    gen_state_t want;
    for (int k = 0; k < FRAME_LEN; k++) begin
      exp_data[k] = model[k];  // Snapshot for this replay
    end
    want = GEN_IDLE;
    @(negedge axis_wr_inf);
    expect_equal("gen_ready", 32'(1'b1), 32'(gen_ready));
    rd_ready = 1'b1;
    gen_en   = 1'b1;  // Start pulse
    @(negedge axis_wr_inf);
    gen_en = 1'b0;
    expect_equal("gen_ready", 32'(1'b0), 32'(gen_ready));
    idx        = 0;
    cycles     = 0;
    prev_stall = 1'b0;
    prev_beat  = '0;
    while (idx < FRAME_LEN) begin
      if (prev_stall) begin
        expect_equal("rd_beat", 32'(prev_beat), 32'(rd_beat));  // Held under stall
      end
      if (extra_start && cycles == 5) begin
        expect_equal("gen_ready", 32'(1'b0), 32'(gen_ready));
        gen_en = 1'b1;  // Must be ignored mid-replay
      end else begin
        gen_en = 1'b0;
      end
      rd_ready = backpressure ? ((next_rand() % 32'd3) != 32'd0) : 1'b1;
      if (rd_beat.valid && rd_ready) begin
        expect_equal("rd_beat.data", 32'(exp_data[idx]), 32'(rd_beat.data));
        expect_equal("rd_beat.last", 32'(idx == FRAME_LEN - 1), 32'(rd_beat.last));
        idx = idx + 1;
      end
      prev_stall = rd_beat.valid & ~rd_ready;
      prev_beat  = rd_beat;
      cycles     = cycles + 1;
      if (cycles > TIMEOUT) begin
        report_timeout("replay beats on rd_beat");
      end
      @(negedge axis_wr_inf);
    end
    gen_en   = 1'b0;
    rd_ready = 1'b1;
    cycles   = 0;
    while (gen_ready !== 1'b1) begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT) begin
        report_timeout($sformatf("producer to reach %s", want.name()));
      end
      @(negedge axis_wr_inf);
    end
    check_idle(12);  // No extra or repeated beats
  endtask

  initial begin
    axis_wr_inf = 1'b0;
    lcg_state   = 32'd16;
    wptr        = 0;
    rst_n       = 1'b0;
    wr_en       = 1'b0;
    wr_beat     = '0;
    gen_en      = 1'b0;
    rd_ready    = 1'b0;
    for (int k = 0; k < DEPTH; k++) begin
      model[k] = 8'h00;
    end
    repeat (8) @(negedge axis_wr_inf);  // Eight reset edges
    rst_n = 1'b1;
    check_idle(4);
    write_frame(FRAME_LEN, 1'b0);       // Full frame, no gaps
    run_replay(1'b0, 1'b0);
    run_replay(1'b1, 1'b0);             // Same data under stall
    offer_while_disabled(12);
    run_replay(1'b1, 1'b0);             // RAM unchanged
    write_frame(FRAME_LEN, 1'b1);
    run_replay(1'b0, 1'b0);
    write_frame(20, 1'b1);              // Overwrites 0 to 19 only
    run_replay(1'b1, 1'b1);
    run_replay(1'b0, 1'b1);
    $display("No errors");
    $finish;
  end

endmodule

// File: src/axis_ram_buffer.sv
// Single clock; DEPTH a power of two, FRAME_LEN at most DEPTH, FIFO_DEPTH at least 4
`timescale 1ns/10ps

module axis_ram_buffer #(
  parameter  int DEPTH      = 4096,
  parameter  int FRAME_LEN  = 4096,
  parameter  int FIFO_DEPTH = 8,
  localparam int ADDR_W     = $clog2(DEPTH)
) (
  input  logic                     axis_wr_inf,
  input  logic                     rst_n,
  input  logic                     wr_en,
  input  axis_ram_pkg::axis_beat_t wr_beat,
  output logic                     wr_ready,
  input  logic                     gen_en,
  output logic                     gen_ready,
  output axis_ram_pkg::axis_beat_t rd_beat,
  input  logic                     rd_ready
);

  import axis_ram_pkg::*;

  logic              ram_we;       // Write side into RAM
  logic [ADDR_W-1:0] ram_waddr;
  logic [DATA_W-1:0] ram_wdata;
  logic [ADDR_W-1:0] raddr;        // Address stream
  logic              raddr_last;
  logic              raddr_ready;
  logic              raddr_fire;
  logic [DATA_W-1:0] ram_rdata;
  axis_beat_t        fifo_beat;    // Buffer to slice
  logic              fifo_ready;

  frame_writer #(.DEPTH(DEPTH)) frame_writer_inst (
    .axis_wr_inf (axis_wr_inf),
    .rst_n       (rst_n),
    .wr_en       (wr_en),
    .wr_beat     (wr_beat),
    .wr_ready    (wr_ready),
    .ram_we      (ram_we),
    .ram_waddr   (ram_waddr),
    .ram_wdata   (ram_wdata)
  );

  frame_ram #(.DEPTH(DEPTH)) frame_ram_inst (
    .axis_wr_inf (axis_wr_inf),
    .we          (ram_we),
    .waddr       (ram_waddr),
    .wdata       (ram_wdata),
    .re          (raddr_fire),  // Read only on handshake
    .raddr       (raddr),
    .rdata       (ram_rdata)
  );

  replay_addr_gen #(.DEPTH(DEPTH), .FRAME_LEN(FRAME_LEN)) replay_addr_gen_inst (
    .axis_wr_inf (axis_wr_inf),
    .rst_n       (rst_n),
    .gen_en      (gen_en),
    .gen_ready   (gen_ready),
    .raddr_valid (),            // Already folded into raddr_fire
    .raddr       (raddr),
    .raddr_last  (raddr_last),
    .raddr_ready (raddr_ready),
    .raddr_fire  (raddr_fire)
  );

  read_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) read_fifo_inst (
    .axis_wr_inf (axis_wr_inf),
    .rst_n       (rst_n),
    .rd_strobe   (raddr_fire),
    .rd_last     (raddr_last),
    .ram_rdata   (ram_rdata),
    .fifo_beat   (fifo_beat),
    .fifo_ready  (fifo_ready),
    .space_ok    (raddr_ready)  // Free-space back-pressure
  );

  axis_out_pipe axis_out_pipe_inst (
    .axis_wr_inf (axis_wr_inf),
    .rst_n       (rst_n),
    .in_beat     (fifo_beat),
    .in_ready    (fifo_ready),
    .rd_beat     (rd_beat),
    .rd_ready    (rd_ready)
  );

endmodule

// File: src/axis_out_pipe.sv
// One-entry slice; in_ready depends combinationally on rd_ready, so it breaks the data path only
`timescale 1ns/10ps

module axis_out_pipe (
  input  logic                     axis_wr_inf,
  input  logic                     rst_n,
  input  axis_ram_pkg::axis_beat_t in_beat,
  output logic                     in_ready,
  output axis_ram_pkg::axis_beat_t rd_beat,
  input  logic                     rd_ready
);

  import axis_ram_pkg::*;

  logic              slot_valid;  // Slice holds a beat
  logic              slot_last;
  logic [DATA_W-1:0] slot_data;
  logic              load;        // Take a new beat

  // Free when empty or when the held beat leaves now
  assign in_ready = ~slot_valid | rd_ready;
  assign load     = in_beat.valid & in_ready;

  assign rd_beat = '{valid: slot_valid,
                     last:  slot_last,
                     data:  slot_data};

  // Valid flag
  always_ff @(posedge axis_wr_inf) begin
    if (!rst_n) begin
      slot_valid <= 1'b0;
    end else if (in_ready) begin
      slot_valid <= in_beat.valid;  // Refill or drain
    end
  end

  // Payload, steady under stall
  always_ff @(posedge axis_wr_inf) begin
    if (load) begin
      slot_last <= in_beat.last;
      slot_data <= in_beat.data;
    end
  end

endmodule

// File: src/read_fifo.sv
// Assumes a one-cycle RAM read latency; space_ok keeps two entries free for the address in flight
`timescale 1ns/10ps

module read_fifo #(
  parameter  int FIFO_DEPTH = 8,
  localparam int PTR_W      = $clog2(FIFO_DEPTH),
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
  input  logic                            axis_wr_inf,
  input  logic                            rst_n,
  input  logic                            rd_strobe,
  input  logic                            rd_last,
  input  logic [axis_ram_pkg::DATA_W-1:0] ram_rdata,
  output axis_ram_pkg::axis_beat_t        fifo_beat,
  input  logic                            fifo_ready,
  output logic                            space_ok
);

  import axis_ram_pkg::*;

  logic [DATA_W:0]   mem [FIFO_DEPTH];  // {last, data} per entry
  logic              strobe_q;          // Read strobe lined up with RAM data
  logic              last_q;
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;             // Occupancy
  logic              push;
  logic              pop;
  logic              not_empty;

  assign push      = strobe_q;                 // RAM data valid now
  assign not_empty = (count != '0);
  assign pop       = not_empty & fifo_ready;
  assign space_ok  = (count < CNT_W'(FIFO_DEPTH - 1));  // At least two free

  assign fifo_beat = '{valid: not_empty,
                       last:  mem[rd_ptr][DATA_W],
                       data:  mem[rd_ptr][DATA_W-1:0]};

  // Match the RAM latency
  always_ff @(posedge axis_wr_inf) begin
    if (!rst_n) begin
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= rd_strobe;
    end
  end

  always_ff @(posedge axis_wr_inf) begin
    last_q <= rd_last;  // Qualified by strobe_q
  end

  // Entry storage
  always_ff @(posedge axis_wr_inf) begin
    if (push) begin
      mem[wr_ptr] <= {last_q, ram_rdata};
    end
  end

  // Pointers and occupancy
  always_ff @(posedge axis_wr_inf) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        if (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
          wr_ptr <= '0;  // Circular wrap
        end else begin
          wr_ptr <= wr_ptr + PTR_W'(1);
        end
      end
      if (pop) begin
        if (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + PTR_W'(1);
        end
      end
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

// File: src/replay_addr_gen.sv
// FRAME_LEN must not exceed DEPTH; a start pulse while a replay runs is ignored
`timescale 1ns/10ps

module replay_addr_gen #(
  parameter  int DEPTH     = 4096,
  parameter  int FRAME_LEN = 4096,
  localparam int ADDR_W    = $clog2(DEPTH)
) (
  input  logic              axis_wr_inf,
  input  logic              rst_n,
  input  logic              gen_en,
  output logic              gen_ready,
  output logic              raddr_valid,
  output logic [ADDR_W-1:0] raddr,
  output logic              raddr_last,
  input  logic              raddr_ready,
  output logic              raddr_fire
);

  import axis_ram_pkg::*;

  gen_state_t state;     // Producer FSM
  logic       addr_end;  // Current address is the final one

  assign addr_end    = (raddr == ADDR_W'(FRAME_LEN - 1));
  assign gen_ready   = (state == GEN_IDLE);         // Free for a new start
  assign raddr_valid = (state == GEN_RUN);
  assign raddr_last  = raddr_valid & addr_end;      // Marks the final beat
  assign raddr_fire  = raddr_valid & raddr_ready;   // Single handshake term

  always_ff @(posedge axis_wr_inf) begin
    if (!rst_n) begin
      state <= GEN_IDLE;
      raddr <= '0;
    end else begin
      case (state)
        GEN_IDLE: begin
          if (gen_en) begin
            state <= GEN_RUN;  // Start replay
            raddr <= '0;
          end
        end
        GEN_RUN: begin
          if (raddr_fire) begin
            if (addr_end) begin
              state <= GEN_IDLE;  // Frame done
              raddr <= '0;
            end else begin
              raddr <= raddr + ADDR_W'(1);
            end
          end
        end
      endcase
    end
  end

endmodule

// File: src/frame_writer.sv
// DEPTH must be a power of two so the write address wraps by itself; ready is the wr_en level only
`timescale 1ns/10ps

module frame_writer #(
  parameter  int DEPTH  = 4096,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input  logic                            axis_wr_inf,
  input  logic                            rst_n,
  input  logic                            wr_en,
  input  axis_ram_pkg::axis_beat_t        wr_beat,
  output logic                            wr_ready,
  output logic                            ram_we,
  output logic [ADDR_W-1:0]               ram_waddr,
  output logic [axis_ram_pkg::DATA_W-1:0] ram_wdata
);

  logic wr_fire;  // Beat accepted this cycle

  assign wr_ready  = wr_en;                  // No internal stall
  assign wr_fire   = wr_beat.valid & wr_en;  // Handshake
  assign ram_we    = wr_fire;
  assign ram_wdata = wr_beat.data;           // Straight into RAM

  // Write address, back to zero after last
  always_ff @(posedge axis_wr_inf) begin
    if (!rst_n) begin
      ram_waddr <= '0;
    end else if (wr_fire) begin
      if (wr_beat.last) begin
        ram_waddr <= '0;                        // Next frame starts at 0
      end else begin
        ram_waddr <= ram_waddr + ADDR_W'(1);  // Wraps at DEPTH
      end
    end
  end

endmodule

// File: src/frame_ram.sv
// Read data is registered and valid one cycle after re; read and write to one address at once returns old data
`timescale 1ns/10ps

module frame_ram #(
  parameter  int DEPTH  = 4096,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input  logic                            axis_wr_inf,
  input  logic                            we,
  input  logic [ADDR_W-1:0]               waddr,
  input  logic [axis_ram_pkg::DATA_W-1:0] wdata,
  input  logic                            re,
  input  logic [ADDR_W-1:0]               raddr,
  output logic [axis_ram_pkg::DATA_W-1:0] rdata
);

  import axis_ram_pkg::*;

  logic [DATA_W-1:0] mem [DEPTH];  // Frame storage

  // Write port
  always_ff @(posedge axis_wr_inf) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read port, one cycle latency
  always_ff @(posedge axis_wr_inf) begin
    if (re) begin
      rdata <= mem[raddr];  // Held while re is low
    end
  end

endmodule

// File: src/axis_ram_pkg.sv
// Shared stream types for the replay buffer; data is one byte wide and carries no tkeep or tuser
package axis_ram_pkg;

  // Byte lane of every stream in the design
  parameter int DATA_W = 8;

  // One stream beat without its ready, which travels the other way
  typedef struct packed {
    logic              valid;  // Beat present
    logic              last;   // Final beat of a frame
    logic [DATA_W-1:0] data;   // Payload byte
  } axis_beat_t;

  // Replay producer states
  typedef enum logic {
    GEN_IDLE = 1'b0,  // Waiting for a start pulse
    GEN_RUN  = 1'b1   // Issuing read addresses
  } gen_state_t;

endpackage
